//--- common/renamePkg.sv
`include "rename_consts.svh"

package renamePkg;

    typedef logic [`RN_WORD_BITS-1:0] word_t;
    typedef logic [`RN_ARCH_BITS-1:0] archReg_t;
    typedef logic [`RN_PHYS_BITS-1:0] physReg_t;
    typedef logic [`RN_ROB_BITS-1:0]  robTag_t;

    // one decoded instruction as it leaves decode
    typedef struct packed {
        word_t                          pc;
        word_t                          instr;
        word_t                          imm;
        archReg_t                       srcA;
        archReg_t                       srcB;
        archReg_t                       dest;
        logic [`RN_ALU_CTRL_BITS-1:0]   aluCtrl;
        logic [`RN_SHAMT_BITS-1:0]      shamt;
        logic                           aluSrc;   // operand B is the immediate
        logic                           regWrite;
        logic                           memRead;
        logic                           memWrite;
    } decodedInstr_t;

    typedef struct packed {
        logic [`RN_ALU_CTRL_BITS-1:0]   aluCtrl;
        logic                           aluSrc;
        word_t                          imm;
        physReg_t                       physA;
        logic                           readyA;
        physReg_t                       physB;
        logic                           readyB;
        logic [`RN_SHAMT_BITS-1:0]      shamt;
        logic                           hasDest;
        physReg_t                       physDest;   // zero when hasDest is clear
        robTag_t                        robTag;
        logic                           memWrite;
        logic                           memRead;
    } issueEntry_t;

    typedef struct packed {
        logic                           isStore;
        physReg_t                       physAddrBase;   // source A holds the address base
        physReg_t                       physDest;
        robTag_t                        robTag;
    } lsqEntry_t;

    typedef struct packed {
        logic                           valid;
        physReg_t                       phys;
        robTag_t                        robTag;
    } writeback_t;

    typedef struct packed {
        archReg_t                       archDest;
        logic                           hasDest;
        physReg_t                       newPhys;
        physReg_t                       oldPhys;   // returns to the free list at commit
        word_t                          pc;
    } robCommit_t;

endpackage

//--- common/rename_consts.svh
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// register file sizes
`define RN_NUM_ARCH       32
`define RN_NUM_PHYS       64
`define RN_ARCH_BITS      5
`define RN_PHYS_BITS      6

// reorder buffer
`define RN_ROB_DEPTH      16
`define RN_ROB_BITS       4

// datapath fields carried through rename
`define RN_WORD_BITS      32
`define RN_ALU_CTRL_BITS  6
`define RN_SHAMT_BITS     5

`endif

//--- compile.f
+incdir+common
common/renamePkg.sv
rename/renameStage.sv
rename/registerAliasTable.sv
rename/freeList.sv
hdl/reorderBuffer.sv
hdl/renameTop.sv
dv/rename_checker.sv
dv/renameTb.sv

//--- dv/renameTb.sv
`timescale 1ns/100ps
`include "rename_consts.svh"

module renameTb;

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_INSTR   = 400;
    localparam int INSTR_BOUND = 20;   // worst-case cycles per instruction under back-pressure
    localparam int WATCHDOG_NS = (NUM_INSTR * INSTR_BOUND + 50) * CLK_PERIOD;

    logic                       CLK;
    logic                       RESET;
    logic                       instrValid;
    logic                       issueFull;
    logic                       lsqFull;
    logic                       stall;
    logic                       issueValid;
    logic                       lsqValid;
    logic                       commitValid;
    renamePkg::decodedInstr_t   instr;
    renamePkg::writeback_t      writeback;
    renamePkg::issueEntry_t     issue;
    renamePkg::lsqEntry_t       lsq;
    renamePkg::robCommit_t      commit;

    renamePkg::physReg_t        mapModel [`RN_NUM_ARCH];
    logic [`RN_NUM_PHYS-1:0]    busyModel;
    logic [`RN_ROB_DEPTH-1:0]   doneModel;
    renamePkg::physReg_t        freeModel [$];   // front is the next destination register
    renamePkg::robCommit_t      robModel [$];    // front is the oldest instruction
    renamePkg::robTag_t         headTag;
    renamePkg::robTag_t         tailTag;
    logic                       expIssueValid;
    logic                       expLsqValid;
    logic                       expCommitValid;
    logic                       lastAccept;
    renamePkg::issueEntry_t     expIssue;
    renamePkg::lsqEntry_t       expLsq;
    renamePkg::robCommit_t      expCommit;
    logic [31:0]                rngState;
    renamePkg::word_t           nextPc;
    int                         numGenerated;
    int                         numAccepted;

    renameTop renameTop_i (
        .CLK(CLK), .RESET(RESET), .instrValid(instrValid), .instr(instr),
        .issueFull(issueFull), .lsqFull(lsqFull), .writeback(writeback), .stall(stall),
        .issueValid(issueValid), .issue(issue), .lsqValid(lsqValid), .lsq(lsq),
        .commitValid(commitValid), .commit(commit)
    );

    bind renameTop rename_checker rename_checker_i (
        .CLK(CLK), .RESET(RESET), .stall(stall),
        .issueValid(issueValid), .issue(issue), .lsqValid(lsqValid), .lsq(lsq),
        .commitValid(commitValid), .robTail(robTail)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $fatal(1, "simulation hung");
    end

    function automatic logic [31:0] xorshiftNext();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic chance(input int percent);
        return (xorshiftNext() % 100) < percent;
    endfunction

    function automatic renamePkg::decodedInstr_t randomInstr(input renamePkg::word_t pc);
        renamePkg::decodedInstr_t d;
        logic [31:0]              r;
        d         = '0;
        r         = xorshiftNext();
        d.pc      = pc;
        d.instr   = xorshiftNext();
        d.imm     = xorshiftNext();
        d.srcA    = r[4:0];
        d.srcB    = r[9:5];
        d.dest    = r[14:10];
        d.aluCtrl = r[20:15];
        d.shamt   = r[25:21];
        case (r[28:26])
            3'd0, 3'd1: begin   // load
                d.memRead  = 1'b1;
                d.regWrite = 1'b1;
                d.aluSrc   = 1'b1;
            end
            3'd2: begin   // store
                d.memWrite = 1'b1;
                d.aluSrc   = 1'b1;
            end
            default: begin
                d.regWrite = r[29] || r[30];
                d.aluSrc   = r[31];
            end
        endcase
        return d;
    endfunction

    // an operand is ready when idle, written back this cycle, or r0
    function automatic logic isReady(input renamePkg::physReg_t p);
        return !busyModel[p] || (writeback.valid && (writeback.phys == p)) || (p == '0);
    endfunction

    task automatic stopOnError();
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, name, got, exp);
            stopOnError();
        end
    endtask

    task automatic checkIssue(input renamePkg::issueEntry_t got,
                              input renamePkg::issueEntry_t exp);
        if (got !== exp) begin
            $display("ERR %0t: issue entry got %h expected %h", $time, got, exp);
            stopOnError();
        end
    endtask

    task automatic checkLsq(input renamePkg::lsqEntry_t got, input renamePkg::lsqEntry_t exp);
        if (got !== exp) begin
            $display("ERR %0t: LSQ entry got %h expected %h", $time, got, exp);
            stopOnError();
        end
    endtask

    task automatic checkCommit(input renamePkg::robCommit_t got,
                               input renamePkg::robCommit_t exp);
        if (got !== exp) begin
            $display("ERR %0t: commit of pc %h got %h expected %h", $time, exp.pc, got, exp);
            stopOnError();
        end
    endtask

    task automatic resetModel();
        for (int i = 0; i < `RN_NUM_ARCH; i++) begin
            mapModel[i] = renamePkg::physReg_t'(i);
            freeModel.push_back(renamePkg::physReg_t'(i + `RN_NUM_ARCH));
        end
        busyModel      = '0;
        doneModel      = '0;
        headTag        = '0;
        tailTag        = '0;
        expIssueValid  = 1'b0;
        expLsqValid    = 1'b0;
        expCommitValid = 1'b0;
        lastAccept     = 1'b0;
    endtask

    // random out-of-order writeback of an in-flight entry not yet completed
    task automatic pickWriteback(output renamePkg::writeback_t wb);
        int                 count;
        int                 start;
        int                 idx;
        logic               found;
        renamePkg::robTag_t tag;
        wb    = '0;
        found = 1'b0;
        count = robModel.size();
        start = (count != 0) ? int'(xorshiftNext() % count) : 0;
        for (int k = 0; k < count && !found; k++) begin
            idx = (start + k) % count;
            tag = headTag + renamePkg::robTag_t'(idx);
            if (!doneModel[tag]) begin
                found     = 1'b1;
                wb.valid  = 1'b1;
                wb.robTag = tag;
                wb.phys   = robModel[idx].hasDest ? robModel[idx].newPhys : '0;
            end
        end
    endtask

    task automatic driveInputs();
        renamePkg::writeback_t wb;
        logic                  draining;
        draining = (numGenerated == NUM_INSTR);
        if (!instrValid || lastAccept) begin   // a stalled instruction is held
            if (!draining && chance(90)) begin
                instr        <= randomInstr(nextPc);
                instrValid   <= 1'b1;
                nextPc       = nextPc + 32'd4;
                numGenerated = numGenerated + 1;
            end else begin
                instrValid <= 1'b0;
            end
        end
        issueFull <= !draining && chance(12);
        lsqFull   <= !draining && chance(12);
        wb = '0;
        if (draining || chance(60)) begin
            pickWriteback(wb);
        end
        writeback <= wb;
    endtask

    task automatic checkOutputs();
        checkFlag("issueValid", issueValid, expIssueValid);
        if (expIssueValid) begin
            checkIssue(issue, expIssue);
        end
        checkFlag("lsqValid", lsqValid, expLsqValid);
        if (expLsqValid) begin
            checkLsq(lsq, expLsq);
        end
        checkFlag("commitValid", commitValid, expCommitValid);
        if (expCommitValid) begin
            checkCommit(commit, expCommit);
        end
    endtask

    // predicts stall for the current inputs and advances the model over the next edge
    task automatic stepModel();
        logic                   writesReg;
        logic                   isMem;
        logic                   stallExp;
        logic                   accNow;
        renamePkg::physReg_t    physA;
        renamePkg::physReg_t    physB;
        renamePkg::physReg_t    destPhys;
        renamePkg::robCommit_t  entry;
        writesReg = instr.regWrite && (instr.dest != '0);
        isMem     = instr.memRead || instr.memWrite;
        stallExp  = (robModel.size() == `RN_ROB_DEPTH) || (writesReg && freeModel.size() == 0)
                 || issueFull || (isMem && lsqFull);
        checkFlag("stall", stall, stallExp);
        accNow   = instrValid && !stallExp;
        physA    = mapModel[instr.srcA];
        physB    = mapModel[instr.srcB];
        destPhys = (writesReg && freeModel.size() != 0) ? freeModel[0] : '0;
        expIssue = '0;
        expIssue.aluCtrl  = instr.aluCtrl;
        expIssue.aluSrc   = instr.aluSrc;
        expIssue.imm      = instr.imm;
        expIssue.physA    = physA;
        expIssue.readyA   = isReady(physA);
        expIssue.physB    = physB;
        expIssue.readyB   = isReady(physB) || instr.aluSrc;
        expIssue.shamt    = instr.shamt;
        expIssue.hasDest  = writesReg;
        expIssue.physDest = destPhys;
        expIssue.robTag   = tailTag;
        expIssue.memWrite = instr.memWrite;
        expIssue.memRead  = instr.memRead;
        expLsq = '{isStore: instr.memWrite, physAddrBase: physA, physDest: destPhys,
                   robTag: tailTag};
        entry  = '{archDest: instr.dest, hasDest: writesReg, newPhys: destPhys,
                   oldPhys: writesReg ? mapModel[instr.dest] : '0, pc: instr.pc};
        expCommitValid = (robModel.size() != 0)
                      && (doneModel[headTag] || (writeback.valid && writeback.robTag == headTag));
        if (expCommitValid) begin
            expCommit = robModel.pop_front();
            if (expCommit.hasDest) begin
                freeModel.push_back(expCommit.oldPhys);
            end
            headTag = headTag + 1'b1;
        end
        if (writeback.valid) begin
            busyModel[writeback.phys]   = 1'b0;
            doneModel[writeback.robTag] = 1'b1;
        end
        if (accNow) begin
            if (writesReg) begin
                freeModel.delete(0);
                mapModel[instr.dest] = destPhys;
                busyModel[destPhys]  = 1'b1;
            end
            doneModel[tailTag] = 1'b0;
            robModel.push_back(entry);
            tailTag     = tailTag + 1'b1;
            numAccepted = numAccepted + 1;
        end
        expIssueValid = accNow;
        expLsqValid   = accNow && isMem;
        lastAccept    = accNow;
    endtask

    initial begin
        RESET        = 1'b0;
        instrValid   = 1'b0;
        instr        = '0;
        issueFull    = 1'b0;
        lsqFull      = 1'b0;
        writeback    = '0;
        rngState     = 32'd4820;
        nextPc       = 32'h0040_0000;
        numGenerated = 0;
        numAccepted  = 0;
        resetModel();
        repeat (4) @(posedge CLK);
        RESET <= 1'b1;
        while (!(numAccepted == NUM_INSTR && robModel.size() == 0
                 && !expCommitValid && !expIssueValid)) begin
            @(posedge CLK);
            driveInputs();
            @(negedge CLK);   // outputs and stall are settled here
            checkOutputs();
            stepModel();
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- dv/rename_checker.sv
`timescale 1ns/100ps

module rename_checker (
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic                        stall,
    input  logic                        issueValid,
    input  renamePkg::issueEntry_t      issue,
    input  logic                        lsqValid,
    input  renamePkg::lsqEntry_t        lsq,
    input  logic                        commitValid,
    input  renamePkg::robTag_t          robTail
);

    // no strobe may leave the block while it is held in reset
    resetQuiet: assert property (@(posedge CLK)
        !RESET |-> (!issueValid && !lsqValid && !commitValid))
        else $error("dispatch or commit strobe high during reset");

    noAcceptOnStall: assert property (@(posedge CLK) disable iff (!RESET)
        stall |=> ($stable(robTail) && !issueValid))   // a stalled cycle allocates nothing
        else $error("instruction accepted while stall is high");

    // back-to-back strobes must belong to successive instructions
    issuePulse: assert property (@(posedge CLK) disable iff (!RESET)
        (issueValid && $past(issueValid))
            |-> (issue.robTag == renamePkg::robTag_t'($past(issue.robTag) + 1'b1)))
        else $error("issue entry held for more than one cycle");

    lsqPulse: assert property (@(posedge CLK) disable iff (!RESET)
        (lsqValid && $past(lsqValid))
            |-> (lsq.robTag == renamePkg::robTag_t'($past(lsq.robTag) + 1'b1)))
        else $error("LSQ entry held for more than one cycle");

endmodule

//--- hdl/renameTop.sv
`timescale 1ns/100ps

module renameTop (
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic                        instrValid,
    input  renamePkg::decodedInstr_t    instr,
    input  logic                        issueFull,
    input  logic                        lsqFull,
    input  renamePkg::writeback_t       writeback,
    output logic                        stall,
    output logic                        issueValid,
    output renamePkg::issueEntry_t      issue,
    output logic                        lsqValid,
    output renamePkg::lsqEntry_t        lsq,
    output logic                        commitValid,
    output renamePkg::robCommit_t       commit
);

    logic                   accept;
    logic                   takeReg;
    logic                   robFull;
    logic                   freeEmpty;
    logic                   freePush;
    logic                   readyA;
    logic                   readyB;
    renamePkg::physReg_t    freeHead;
    renamePkg::physReg_t    freePhys;
    renamePkg::physReg_t    physA;
    renamePkg::physReg_t    physB;
    renamePkg::physReg_t    oldPhys;
    renamePkg::robTag_t     robTail;

    renameStage renameStage_i (
        .CLK(CLK), .RESET(RESET),
        .instrValid(instrValid), .instr(instr),
        .issueFull(issueFull), .lsqFull(lsqFull),
        .robFull(robFull), .freeEmpty(freeEmpty), .freeHead(freeHead),
        .physA(physA), .physB(physB), .readyA(readyA), .readyB(readyB),
        .robTail(robTail),
        .stall(stall), .accept(accept), .takeReg(takeReg),
        .issueValid(issueValid), .issue(issue),
        .lsqValid(lsqValid), .lsq(lsq)
    );

    registerAliasTable registerAliasTable_i (
        .CLK(CLK), .RESET(RESET),
        .srcA(instr.srcA), .srcB(instr.srcB), .dest(instr.dest),
        .rename(takeReg), .newPhys(freeHead),   // new mapping comes straight off the free list
        .writeback(writeback),
        .physA(physA), .physB(physB), .oldPhys(oldPhys),
        .readyA(readyA), .readyB(readyB)
    );

    freeList freeList_i (
        .CLK(CLK), .RESET(RESET),
        .pop(takeReg), .push(freePush), .pushPhys(freePhys),
        .head(freeHead), .empty(freeEmpty)
    );

    reorderBuffer reorderBuffer_i (
        .CLK(CLK), .RESET(RESET),
        .alloc(accept), .allocDest(instr.dest), .allocHasDest(takeReg),
        .allocNewPhys(freeHead), .allocOldPhys(oldPhys), .allocPc(instr.pc),
        .writeback(writeback),
        .tail(robTail), .full(robFull),
        .freePush(freePush), .freePhys(freePhys),   // committed old mapping goes back to the free list
        .commitValid(commitValid), .commit(commit)
    );

endmodule

//--- hdl/reorderBuffer.sv
`timescale 1ns/100ps
`include "rename_consts.svh"

module reorderBuffer (
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic                        alloc,
    input  renamePkg::archReg_t         allocDest,
    input  logic                        allocHasDest,
    input  renamePkg::physReg_t         allocNewPhys,
    input  renamePkg::physReg_t         allocOldPhys,
    input  renamePkg::word_t            allocPc,
    input  renamePkg::writeback_t       writeback,
    output renamePkg::robTag_t          tail,
    output logic                        full,
    output logic                        freePush,
    output renamePkg::physReg_t         freePhys,
    output logic                        commitValid,
    output renamePkg::robCommit_t       commit
);

    renamePkg::robCommit_t      entries [`RN_ROB_DEPTH];
    logic [`RN_ROB_DEPTH-1:0]   done;
    renamePkg::robTag_t         headPtr;
    renamePkg::robTag_t         tailPtr;
    logic [`RN_ROB_BITS:0]      count;
    logic                       headDone;
    logic                       commitNow;
    renamePkg::robCommit_t      allocEntry;

    assign tail = tailPtr;
    assign full = (count == `RN_ROB_DEPTH);

    // the head may retire in the same cycle its writeback arrives
    assign headDone  = done[headPtr]
                    || (writeback.valid && (writeback.robTag == headPtr));
    assign commitNow = (count != '0) && headDone;

    assign freePush = commitNow && entries[headPtr].hasDest;
    assign freePhys = entries[headPtr].oldPhys;

    always_comb begin
        allocEntry          = '0;
        allocEntry.archDest = allocDest;
        allocEntry.hasDest  = allocHasDest;
        allocEntry.newPhys  = allocHasDest ? allocNewPhys : '0;
        allocEntry.oldPhys  = allocHasDest ? allocOldPhys : '0;   // nothing to free otherwise
        allocEntry.pc       = allocPc;
    end

    always_ff @(posedge CLK) begin
        if (alloc) begin
            entries[tailPtr] <= allocEntry;
        end
        if (commitNow) begin
            commit <= entries[headPtr];
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            done        <= '0;
            headPtr     <= '0;
            tailPtr     <= '0;
            count       <= '0;
            commitValid <= 1'b0;
        end else begin
            if (alloc) begin
                done[tailPtr] <= 1'b0;
                tailPtr       <= tailPtr + 1'b1;
            end
            if (writeback.valid) begin
                done[writeback.robTag] <= 1'b1;
            end
            if (commitNow) begin
                headPtr <= headPtr + 1'b1;
            end
            case ({alloc, commitNow})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            commitValid <= commitNow;
        end
    end

endmodule

//--- rename/freeList.sv
`timescale 1ns/100ps
`include "rename_consts.svh"

module freeList (
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic                        pop,
    input  logic                        push,
    input  renamePkg::physReg_t         pushPhys,
    output renamePkg::physReg_t         head,
    output logic                        empty
);

    renamePkg::physReg_t        slots [`RN_NUM_PHYS];
    logic [`RN_PHYS_BITS-1:0]   headPtr;
    logic [`RN_PHYS_BITS-1:0]   tailPtr;
    logic [`RN_PHYS_BITS:0]     count;   // one extra bit so a full list is representable

    assign head  = slots[headPtr];
    assign empty = (count == '0);

    // the upper half of the physical file starts out free, in ascending order
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < `RN_NUM_PHYS; i++) begin
                if (i < `RN_NUM_ARCH) begin
                    slots[i] <= renamePkg::physReg_t'(i + `RN_NUM_ARCH);
                end else begin
                    slots[i] <= '0;
                end
            end
        end else if (push) begin
            slots[tailPtr] <= pushPhys;
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            headPtr <= '0;
            tailPtr <= `RN_PHYS_BITS'(`RN_NUM_ARCH);
            count   <= (`RN_PHYS_BITS+1)'(`RN_NUM_ARCH);
        end else begin
            if (pop) begin
                headPtr <= headPtr + 1'b1;   // wraps at the buffer depth
            end
            if (push) begin
                tailPtr <= tailPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither leave occupancy as is
            endcase
        end
    end

endmodule

//--- rename/registerAliasTable.sv
`timescale 1ns/100ps
`include "rename_consts.svh"

module registerAliasTable (
    input  logic                        CLK,
    input  logic                        RESET,
    input  renamePkg::archReg_t         srcA,
    input  renamePkg::archReg_t         srcB,
    input  renamePkg::archReg_t         dest,
    input  logic                        rename,
    input  renamePkg::physReg_t         newPhys,
    input  renamePkg::writeback_t       writeback,
    output renamePkg::physReg_t         physA,
    output renamePkg::physReg_t         physB,
    output renamePkg::physReg_t         oldPhys,
    output logic                        readyA,
    output logic                        readyB
);

    renamePkg::physReg_t        mapTable [`RN_NUM_ARCH];
    logic [`RN_NUM_PHYS-1:0]    busy;
    logic                       wbHitA;
    logic                       wbHitB;

    // entry 0 keeps its reset value, so r0 always reads phys 0
    assign physA   = mapTable[srcA];
    assign physB   = mapTable[srcB];
    assign oldPhys = mapTable[dest];

    assign wbHitA = writeback.valid && (writeback.phys == physA);
    assign wbHitB = writeback.valid && (writeback.phys == physB);

    // a result arriving this cycle counts as ready already
    assign readyA = !busy[physA] || wbHitA || (physA == '0);
    assign readyB = !busy[physB] || wbHitB || (physB == '0);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < `RN_NUM_ARCH; i++) begin
                mapTable[i] <= renamePkg::physReg_t'(i);   // identity map
            end
            busy <= '0;
        end else begin
            if (writeback.valid) begin
                busy[writeback.phys] <= 1'b0;
            end
            if (rename && (dest != '0)) begin
                mapTable[dest] <= newPhys;
                busy[newPhys]  <= 1'b1;   // fresh register waits for its producer
            end
        end
    end

endmodule

//--- rename/renameStage.sv
`timescale 1ns/100ps

module renameStage (
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic                        instrValid,
    input  renamePkg::decodedInstr_t    instr,
    input  logic                        issueFull,
    input  logic                        lsqFull,
    input  logic                        robFull,
    input  logic                        freeEmpty,
    input  renamePkg::physReg_t         freeHead,
    input  renamePkg::physReg_t         physA,
    input  renamePkg::physReg_t         physB,
    input  logic                        readyA,
    input  logic                        readyB,
    input  renamePkg::robTag_t          robTail,
    output logic                        stall,
    output logic                        accept,
    output logic                        takeReg,
    output logic                        issueValid,
    output renamePkg::issueEntry_t      issue,
    output logic                        lsqValid,
    output renamePkg::lsqEntry_t        lsq
);

    logic                       writesReg;
    logic                       isLoad;
    logic                       isStore;
    logic                       isMem;
    renamePkg::physReg_t        destPhys;
    renamePkg::issueEntry_t     issueNext;
    renamePkg::lsqEntry_t       lsqNext;

    // writes to r0 are discarded, so they need no physical register
    assign writesReg = instr.regWrite && (instr.dest != '0);
    assign isLoad    = instr.memRead;
    assign isStore   = instr.memWrite;
    assign isMem     = isLoad || isStore;

    // stall looks only at resources, never at instrValid
    assign stall = robFull
                || (writesReg && freeEmpty)
                || issueFull
                || (isMem && lsqFull);

    assign accept  = instrValid && !stall;
    assign takeReg = accept && writesReg;   // pops the free list and remaps dest

    assign destPhys = writesReg ? freeHead : '0;

    always_comb begin
        issueNext          = '0;
        issueNext.aluCtrl  = instr.aluCtrl;
        issueNext.aluSrc   = instr.aluSrc;
        issueNext.imm      = instr.imm;
        issueNext.physA    = physA;
        issueNext.readyA   = readyA;
        issueNext.physB    = physB;
        issueNext.readyB   = readyB || instr.aluSrc;   // immediate operand is always ready
        issueNext.shamt    = instr.shamt;
        issueNext.hasDest  = writesReg;
        issueNext.physDest = destPhys;
        issueNext.robTag   = robTail;
        issueNext.memWrite = instr.memWrite;
        issueNext.memRead  = instr.memRead;
    end

    always_comb begin
        lsqNext              = '0;
        lsqNext.isStore      = isStore;
        lsqNext.physAddrBase = physA;
        lsqNext.physDest     = destPhys;   // a load's target, zero for a store
        lsqNext.robTag       = robTail;
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            issueValid <= 1'b0;
            lsqValid   <= 1'b0;
        end else begin
            issueValid <= accept;   // one-cycle pulse per accepted instruction
            lsqValid   <= accept && isMem;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            issue <= issueNext;
            lsq   <= lsqNext;
        end
    end

endmodule
